//--- vlog.f
logic/dispatch_pkg.sv
logic/dispatch_lane_if.sv
logic/operand_fetch.sv
logic/arch_reg_file.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/dispatch_stage.sv
verification/dispatch_stage_tb.sv

//--- verification/dispatch_stage_tb.sv
`timescale 1ns/1ps

module dispatch_stage_tb;

    localparam int LANES   = dispatch_pkg::NUM_LANES;
    localparam int TIMEOUT = 64;  // Cycles allowed per wait loop

    logic clk = 1'b0;
    logic reset;

    // DUT ports
    logic [LANES-1:0]         issue_valid, issue_ready, use_imm, writes_rd;
    dispatch_pkg::opcode_t    issue_opcode [LANES];
    dispatch_pkg::phys_addr_t src_a [LANES], src_b [LANES];
    dispatch_pkg::data_t      imm [LANES];
    dispatch_pkg::arch_addr_t rd_arch [LANES];
    logic [LANES-1:0]         exec_valid, exec_ready, cdb_valid, commit_valid;
    dispatch_pkg::opcode_t    exec_opcode [LANES];
    dispatch_pkg::data_t      exec_a [LANES], exec_b [LANES], cdb_data [LANES];
    dispatch_pkg::rob_idx_t   exec_rd [LANES], commit_rob_idx [LANES];
    dispatch_pkg::phys_addr_t cdb_dest [LANES];
    dispatch_pkg::arch_addr_t commit_addr [LANES];

    // Reference model
    logic [31:0]              rng = 32'd58;
    int                       n_mismatch = 0;
    int                       n_failure = 0;
    dispatch_pkg::rob_idx_t   m_head, m_tail, slot;
    logic                     m_busy [dispatch_pkg::ROB_DEPTH];
    logic                     m_done [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::arch_addr_t m_arch [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::data_t      m_val  [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::data_t      m_regs [dispatch_pkg::ARCH_REGS];

    // Check enables and expected values
    logic                     chk_idle, chk_ready;
    logic [LANES-1:0]         chk_exec, chk_rd, chk_wait, chk_hold, exp_ready, exp_cv;
    dispatch_pkg::opcode_t    exp_op [LANES];
    dispatch_pkg::data_t      exp_a [LANES], exp_b [LANES];
    dispatch_pkg::rob_idx_t   exp_rd [LANES], exp_ci [LANES];
    dispatch_pkg::arch_addr_t exp_ca [LANES];

    always #2 clk = ~clk;  // 4 ns period

    dispatch_stage dispatch_stage_i (.*);

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);  // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic dispatch_pkg::phys_addr_t arch_src(input int n);
        return {1'b0, 5'(n)};
    endfunction

    function automatic dispatch_pkg::phys_addr_t rob_src(input dispatch_pkg::rob_idx_t n);
        return {1'b1, n};
    endfunction

    // Value a source should carry, if already known
    function automatic dispatch_pkg::data_t operand(input dispatch_pkg::phys_addr_t src);
        return src[5] ? m_val[src[4:0]] : m_regs[src[4:0]];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        n_mismatch++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
    endtask

    task automatic report_failure(input string what);
        n_failure++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;  // Drive point
    endtask

    // Wait for the lanes to open, then fix the first allocation slot
    task automatic start_group(input logic [LANES-1:0] lanes);
        int n;
        n = 0;
        while ((issue_ready & lanes) != lanes && n < TIMEOUT) begin
            tick();
            n++;
        end
        if ((issue_ready & lanes) != lanes) report_failure("timeout waiting for issue_ready");
        slot = m_tail;
    endtask

    task automatic drive_lane(input int k, input dispatch_pkg::phys_addr_t a,
                              input dispatch_pkg::phys_addr_t b, input logic imm_en,
                              input dispatch_pkg::arch_addr_t rd);
        issue_valid[k]  = 1'b1;
        issue_opcode[k] = dispatch_pkg::opcode_t'(next_random());
        src_a[k]        = a;
        src_b[k]        = b;
        use_imm[k]      = imm_en;
        imm[k]          = next_random();
        writes_rd[k]    = 1'b1;
        rd_arch[k]      = rd;
        exp_op[k]       = issue_opcode[k];
        exp_a[k]        = operand(a);
        exp_b[k]        = imm_en ? imm[k] : operand(b);
        exp_rd[k]       = slot;
        chk_rd[k]       = rd != '0;  // x0 takes no index
        if (rd != '0) slot = slot + 1'b1;
    endtask

    // Accept edge, then arm the lanes expected valid next cycle
    task automatic dispatch(input logic [LANES-1:0] ready_next);
        tick();
        issue_valid = '0;
        chk_exec    = ready_next;
    endtask

    task automatic bus_drive(input int k, input dispatch_pkg::rob_idx_t idx,
                             input dispatch_pkg::data_t data);
        cdb_valid[k] = 1'b1;
        cdb_dest[k]  = {1'b1, idx};
        cdb_data[k]  = data;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (m_head != m_tail && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (m_head != m_tail) report_failure("timeout waiting for reorder buffer to drain");
    endtask

    // ======================================================================
    // Reference model, updated on the same edges as the DUT
    // ======================================================================
    always @(posedge clk) begin
        logic run;
        if (reset) begin
            m_head = '0;
            m_tail = '0;
            for (int i = 0; i < dispatch_pkg::ROB_DEPTH; i++) begin
                m_busy[i] = 1'b0;
                m_done[i] = 1'b0;
            end
            for (int i = 0; i < dispatch_pkg::ARCH_REGS; i++) m_regs[i] = '0;
        end else begin
            run = 1'b1;
            for (int k = 0; k < LANES; k++) begin  // Retire leading done run
                run = run && m_done[m_head];
                if (run) begin
                    m_regs[m_arch[m_head]] = m_val[m_head];
                    m_busy[m_head] = 1'b0;
                    m_done[m_head] = 1'b0;
                    m_head = m_head + 1'b1;
                end
            end
            for (int k = 0; k < LANES; k++) begin
                if (cdb_valid[k] && cdb_dest[k][5] && m_busy[cdb_dest[k][4:0]] &&
                    !m_done[cdb_dest[k][4:0]]) begin
                    m_done[cdb_dest[k][4:0]] = 1'b1;
                    m_val[cdb_dest[k][4:0]]  = cdb_data[k];
                end
            end
            for (int k = 0; k < LANES; k++) begin  // Driver only issues into ready lanes
                if (issue_valid[k] && writes_rd[k] && rd_arch[k] != '0) begin
                    m_busy[m_tail] = 1'b1;
                    m_done[m_tail] = 1'b0;
                    m_arch[m_tail] = rd_arch[k];
                    m_tail = m_tail + 1'b1;
                end
            end
        end
    end

    always_comb begin
        logic run;
        dispatch_pkg::rob_idx_t idx;
        run = 1'b1;
        for (int k = 0; k < LANES; k++) begin
            idx       = m_head + dispatch_pkg::rob_idx_t'(k);
            run       = run && m_done[idx];
            exp_cv[k] = run;
            exp_ca[k] = m_arch[idx];
            exp_ci[k] = idx;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    a_idle : assert property (@(posedge clk) disable iff (reset) chk_idle |-> exec_valid == '0)
        else report_mismatch("exec_valid", $sampled(exec_valid), 0);
    a_ready : assert property (@(posedge clk) disable iff (reset)
        chk_ready |-> issue_ready == exp_ready)
        else report_mismatch("issue_ready", $sampled(issue_ready), $sampled(exp_ready));
    a_commit : assert property (@(posedge clk) disable iff (reset) commit_valid == exp_cv)
        else report_mismatch("commit_valid", $sampled(commit_valid), $sampled(exp_cv));

    for (genvar k = 0; k < LANES; k++) begin : g_lane_chk
        a_valid : assert property (@(posedge clk) disable iff (reset)
            chk_exec[k] |-> exec_valid[k])
            else report_mismatch($sformatf("exec_valid[%0d]", k), $sampled(exec_valid[k]), 1);
        a_op : assert property (@(posedge clk) disable iff (reset)
            chk_exec[k] |-> exec_opcode[k] == exp_op[k])
            else report_mismatch($sformatf("exec_opcode[%0d]", k),
                                 $sampled(exec_opcode[k]), $sampled(exp_op[k]));
        a_a : assert property (@(posedge clk) disable iff (reset)
            chk_exec[k] |-> exec_a[k] == exp_a[k])
            else report_mismatch($sformatf("exec_a[%0d]", k), $sampled(exec_a[k]),
                                 $sampled(exp_a[k]));
        a_b : assert property (@(posedge clk) disable iff (reset)
            chk_exec[k] |-> exec_b[k] == exp_b[k])
            else report_mismatch($sformatf("exec_b[%0d]", k), $sampled(exec_b[k]),
                                 $sampled(exp_b[k]));
        a_rd : assert property (@(posedge clk) disable iff (reset)
            chk_exec[k] && chk_rd[k] |-> exec_rd[k] == exp_rd[k])
            else report_mismatch($sformatf("exec_rd[%0d]", k), $sampled(exec_rd[k]),
                                 $sampled(exp_rd[k]));
        a_wait : assert property (@(posedge clk) disable iff (reset)
            chk_wait[k] |-> !exec_valid[k])
            else report_mismatch($sformatf("exec_valid[%0d]", k), $sampled(exec_valid[k]), 0);
        a_hold : assert property (@(posedge clk) disable iff (reset)
            chk_hold[k] |-> exec_valid[k] && $stable(exec_opcode[k]) && $stable(exec_a[k]) &&
                $stable(exec_b[k]) && $stable(exec_rd[k]))
            else report_failure($sformatf("lane %0d execution request changed while held", k));
        a_caddr : assert property (@(posedge clk) disable iff (reset)
            exp_cv[k] |-> commit_addr[k] == exp_ca[k])
            else report_mismatch($sformatf("commit_addr[%0d]", k), $sampled(commit_addr[k]),
                                 $sampled(exp_ca[k]));
        a_cidx : assert property (@(posedge clk) disable iff (reset)
            exp_cv[k] |-> commit_rob_idx[k] == exp_ci[k])
            else report_mismatch($sformatf("commit_rob_idx[%0d]", k),
                                 $sampled(commit_rob_idx[k]), $sampled(exp_ci[k]));
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        dispatch_pkg::rob_idx_t base;
        dispatch_pkg::data_t    v0, v1, v2;
        reset       = 1'b1;
        issue_valid = '0;
        use_imm     = '0;
        writes_rd   = '0;
        exec_ready  = '1;
        cdb_valid   = '0;
        {chk_idle, chk_ready, chk_exec, chk_rd, chk_wait, chk_hold, exp_ready} = '0;
        for (int k = 0; k < LANES; k++) begin
            issue_opcode[k] = '0;
            src_a[k]        = '0;
            src_b[k]        = '0;
            imm[k]          = '0;
            rd_arch[k]      = '0;
            cdb_dest[k]     = '0;
            cdb_data[k]     = '0;
        end
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        chk_idle  = 1'b1;  // Quiet pipeline after reset
        chk_ready = 1'b1;
        exp_ready = '1;
        repeat (3) tick();
        chk_idle  = 1'b0;
        chk_ready = 1'b0;

        // Three allocations in one group, all operands ready
        start_group('1);
        base = slot;
        drive_lane(0, arch_src(1), arch_src(2), 1'b0, 5'd5);
        drive_lane(1, arch_src(3), arch_src(0), 1'b1, 5'd6);
        drive_lane(2, arch_src(4), arch_src(4), 1'b1, 5'd7);
        dispatch('1);
        tick();
        chk_exec = '0;

        // Wakeup on pending entries, lane 0 writes x0
        start_group('1);
        drive_lane(0, rob_src(base + 5'd1), arch_src(5), 1'b0, 5'd0);
        drive_lane(1, arch_src(0), rob_src(base + 5'd2), 1'b0, 5'd9);
        drive_lane(2, rob_src(base), arch_src(1), 1'b1, 5'd10);
        dispatch('0);
        chk_wait = '1;
        repeat (2) tick();
        v0 = next_random();
        v2 = next_random();
        bus_drive(0, base + 5'd2, v2);  // Out of order
        bus_drive(1, base, v0);
        cdb_valid[2] = 1'b1;            // ARF destination, ignored
        cdb_dest[2]  = {1'b0, base + 5'd1};
        cdb_data[2]  = next_random();
        exp_b[1] = v2;
        exp_a[2] = v0;
        tick();
        cdb_valid = '0;
        chk_wait  = 3'b001;
        chk_exec  = 3'b110;
        v1 = next_random();
        bus_drive(0, base + 5'd1, v1);
        exp_a[0] = v1;
        tick();
        cdb_valid = '0;
        chk_wait  = '0;
        chk_exec  = 3'b001;
        tick();
        chk_exec = '0;
        bus_drive(1, base + 5'd4, next_random());
        bus_drive(2, base + 5'd3, next_random());
        tick();
        cdb_valid = '0;
        wait_drain();

        // Committed values seen by later readers
        start_group('1);
        drive_lane(0, arch_src(5), arch_src(6), 1'b0, 5'd11);
        drive_lane(1, arch_src(7), arch_src(9), 1'b0, 5'd12);
        drive_lane(2, arch_src(10), arch_src(0), 1'b1, 5'd13);
        dispatch('1);
        tick();
        chk_exec = '0;
        for (int k = 0; k < LANES; k++) bus_drive(k, exp_rd[k], next_random());
        tick();
        cdb_valid = '0;
        wait_drain();

        // Back-pressure on lane 2 only
        start_group(3'b100);
        exec_ready[2] = 1'b0;
        drive_lane(2, arch_src(11), arch_src(12), 1'b0, 5'd14);
        dispatch(3'b100);
        chk_ready = 1'b1;
        exp_ready = 3'b011;
        tick();
        chk_hold[2] = 1'b1;
        repeat (3) tick();
        exec_ready[2] = 1'b1;  // Taken at the next edge
        tick();
        exec_ready[2] = 1'b0;
        chk_exec  = '0;
        chk_hold  = '0;
        exp_ready = '1;
        tick();
        chk_ready  = 1'b0;
        exec_ready = '1;
        bus_drive(0, exp_rd[2], next_random());
        tick();
        cdb_valid = '0;
        wait_drain();
        repeat (2) tick();

        $display("mismatches %0d, other failures %0d", n_mismatch, n_failure);
        if (n_mismatch + n_failure == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                     clk,
    input  logic                     reset,
    // Issue side
    input  logic [dispatch_pkg::NUM_LANES-1:0] issue_valid,
    output logic [dispatch_pkg::NUM_LANES-1:0] issue_ready,
    input  dispatch_pkg::opcode_t    issue_opcode   [dispatch_pkg::NUM_LANES],
    input  dispatch_pkg::phys_addr_t src_a          [dispatch_pkg::NUM_LANES],
    input  dispatch_pkg::phys_addr_t src_b          [dispatch_pkg::NUM_LANES],
    input  logic [dispatch_pkg::NUM_LANES-1:0] use_imm,
    input  dispatch_pkg::data_t      imm            [dispatch_pkg::NUM_LANES],
    input  logic [dispatch_pkg::NUM_LANES-1:0] writes_rd,
    input  dispatch_pkg::arch_addr_t rd_arch        [dispatch_pkg::NUM_LANES],
    // Execution side
    output logic [dispatch_pkg::NUM_LANES-1:0] exec_valid,
    input  logic [dispatch_pkg::NUM_LANES-1:0] exec_ready,
    output dispatch_pkg::opcode_t    exec_opcode    [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::data_t      exec_a         [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::data_t      exec_b         [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::rob_idx_t   exec_rd        [dispatch_pkg::NUM_LANES],
    // Result bus
    input  logic [dispatch_pkg::NUM_LANES-1:0] cdb_valid,
    input  dispatch_pkg::phys_addr_t cdb_dest       [dispatch_pkg::NUM_LANES],
    input  dispatch_pkg::data_t      cdb_data       [dispatch_pkg::NUM_LANES],
    // Commit side
    output logic [dispatch_pkg::NUM_LANES-1:0] commit_valid,
    output dispatch_pkg::arch_addr_t commit_addr    [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::rob_idx_t   commit_rob_idx [dispatch_pkg::NUM_LANES]
);

    logic [dispatch_pkg::NUM_LANES-1:0] accept, alloc_en, rs_empty;
    logic                               rob_has_room;
    dispatch_pkg::rob_idx_t   alloc_idx   [dispatch_pkg::NUM_LANES];
    dispatch_pkg::data_t      commit_data [dispatch_pkg::NUM_LANES];
    dispatch_pkg::arch_addr_t rf_addr     [2*dispatch_pkg::NUM_LANES];  // A even, B odd
    dispatch_pkg::data_t      rf_data     [2*dispatch_pkg::NUM_LANES];
    dispatch_pkg::rob_idx_t   rob_addr    [2*dispatch_pkg::NUM_LANES];
    dispatch_pkg::data_t      rob_data    [2*dispatch_pkg::NUM_LANES];
    logic [2*dispatch_pkg::NUM_LANES-1:0] rob_done;

    assign issue_ready = rs_empty & {dispatch_pkg::NUM_LANES{rob_has_room}};
    assign accept      = issue_valid & issue_ready;

    // =====================================================================
    // Shared ROB and ARF
    // =====================================================================
    reorder_buffer rob_i (
        .clk, .reset,
        .alloc_en, .alloc_arch(rd_arch), .alloc_idx, .has_room(rob_has_room),
        .cdb_valid, .cdb_dest, .cdb_data,
        .rd_idx(rob_addr), .rd_data(rob_data), .rd_done(rob_done),
        .commit_valid, .commit_addr, .commit_data, .commit_idx(commit_rob_idx)
    );

    arch_reg_file arf_i (
        .clk, .reset, .rd_addr(rf_addr), .rd_data(rf_data),
        .commit_valid, .commit_addr, .commit_data
    );

    // =====================================================================
    // Per lane fetch and station
    // =====================================================================
    for (genvar k = 0; k < dispatch_pkg::NUM_LANES; k++) begin : g_lane
        dispatch_lane_if lane_if ();

        assign alloc_en[k]    = accept[k] && writes_rd[k] && rd_arch[k] != '0;  // No x0
        assign rf_addr[2*k]   = src_a[k][4:0];
        assign rf_addr[2*k+1] = src_b[k][4:0];
        assign rob_addr[2*k]   = src_a[k][4:0];
        assign rob_addr[2*k+1] = src_b[k][4:0];

        operand_fetch fetch_i (
            .src_a(src_a[k]), .src_b(src_b[k]), .use_imm(use_imm[k]), .imm(imm[k]),
            .opcode(issue_opcode[k]), .rd_rob_idx(alloc_idx[k]),
            .rf_a(rf_data[2*k]), .rf_b(rf_data[2*k+1]),
            .rob_a(rob_data[2*k]), .rob_b(rob_data[2*k+1]),
            .rob_a_done(rob_done[2*k]), .rob_b_done(rob_done[2*k+1]),
            .lane(lane_if.fetch)
        );

        reservation_station rs_i (
            .clk, .reset, .load(accept[k]), .lane(lane_if.station),
            .cdb_valid, .cdb_dest, .cdb_data, .empty(rs_empty[k]),
            .exec_valid(exec_valid[k]), .exec_ready(exec_ready[k]),
            .exec_opcode(exec_opcode[k]), .exec_a(exec_a[k]), .exec_b(exec_b[k]),
            .exec_rd(exec_rd[k])
        );
    end

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    dispatch_lane_if.station         lane,
    input  logic [dispatch_pkg::NUM_LANES-1:0] cdb_valid,
    input  dispatch_pkg::phys_addr_t cdb_dest [dispatch_pkg::NUM_LANES],
    input  dispatch_pkg::data_t      cdb_data [dispatch_pkg::NUM_LANES],
    output logic                     empty,
    output logic                     exec_valid,
    input  logic                     exec_ready,
    output dispatch_pkg::opcode_t    exec_opcode,
    output dispatch_pkg::data_t      exec_a,
    output dispatch_pkg::data_t      exec_b,
    output dispatch_pkg::rob_idx_t   exec_rd
);

    dispatch_pkg::rs_state_e state, state_nxt;
    dispatch_pkg::rob_idx_t  a_tag, b_tag;
    logic                    a_ready, b_ready, a_ready_nxt, b_ready_nxt;
    dispatch_pkg::data_t     a_data_nxt, b_data_nxt;

    // =====================================================================
    // Wakeup, from the lane while loading or from the held entry
    // =====================================================================
    always_comb begin
        dispatch_pkg::rob_idx_t ta, tb;
        ta          = load ? lane.a_tag   : a_tag;
        tb          = load ? lane.b_tag   : b_tag;
        a_ready_nxt = load ? lane.a_ready : a_ready;
        b_ready_nxt = load ? lane.b_ready : b_ready;
        a_data_nxt  = load ? lane.a_data  : exec_a;
        b_data_nxt  = load ? lane.b_data  : exec_b;
        for (int k = 0; k < dispatch_pkg::NUM_LANES; k++) begin
            if (cdb_valid[k] && cdb_dest[k][5]) begin  // ARF dests ignored
                if (!a_ready_nxt && cdb_dest[k][4:0] == ta) begin
                    a_ready_nxt = 1'b1;
                    a_data_nxt  = cdb_data[k];
                end
                if (!b_ready_nxt && cdb_dest[k][4:0] == tb) begin
                    b_ready_nxt = 1'b1;
                    b_data_nxt  = cdb_data[k];
                end
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dispatch_pkg::RS_EMPTY:   if (load) state_nxt = (a_ready_nxt && b_ready_nxt) ?
                                          dispatch_pkg::RS_READY : dispatch_pkg::RS_WAITING;
            dispatch_pkg::RS_WAITING: if (a_ready_nxt && b_ready_nxt)
                                          state_nxt = dispatch_pkg::RS_READY;
            dispatch_pkg::RS_READY:   if (exec_ready) state_nxt = dispatch_pkg::RS_EMPTY;
            default:                  state_nxt = dispatch_pkg::RS_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) state <= dispatch_pkg::RS_EMPTY;
        else       state <= state_nxt;
    end

    // Entry payload, frozen once ready
    always_ff @(posedge clk) begin
        if (load) begin
            exec_opcode <= lane.opcode;
            exec_rd     <= lane.rd_rob_idx;
            a_tag       <= lane.a_tag;
            b_tag       <= lane.b_tag;
        end
        if (load || state == dispatch_pkg::RS_WAITING) begin
            a_ready <= a_ready_nxt;
            b_ready <= b_ready_nxt;
            exec_a  <= a_data_nxt;
            exec_b  <= b_data_nxt;
        end
    end

    assign empty      = state == dispatch_pkg::RS_EMPTY;
    assign exec_valid = state == dispatch_pkg::RS_READY;

    // Unit sees a steady request until it takes it
    a_hold : assert property (@(posedge clk) disable iff (reset)
        exec_valid && !exec_ready |=> exec_valid && $stable(exec_opcode) &&
            $stable(exec_a) && $stable(exec_b) && $stable(exec_rd));

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                     clk,
    input  logic                     reset,
    // Allocation
    input  logic [dispatch_pkg::NUM_LANES-1:0] alloc_en,
    input  dispatch_pkg::arch_addr_t alloc_arch   [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::rob_idx_t   alloc_idx    [dispatch_pkg::NUM_LANES],
    output logic                     has_room,
    // Result bus
    input  logic [dispatch_pkg::NUM_LANES-1:0] cdb_valid,
    input  dispatch_pkg::phys_addr_t cdb_dest     [dispatch_pkg::NUM_LANES],
    input  dispatch_pkg::data_t      cdb_data     [dispatch_pkg::NUM_LANES],
    // Operand reads, two per lane
    input  dispatch_pkg::rob_idx_t   rd_idx       [2*dispatch_pkg::NUM_LANES],
    output dispatch_pkg::data_t      rd_data      [2*dispatch_pkg::NUM_LANES],
    output logic [2*dispatch_pkg::NUM_LANES-1:0] rd_done,
    // Retirement
    output logic [dispatch_pkg::NUM_LANES-1:0] commit_valid,
    output dispatch_pkg::arch_addr_t commit_addr  [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::data_t      commit_data  [dispatch_pkg::NUM_LANES],
    output dispatch_pkg::rob_idx_t   commit_idx   [dispatch_pkg::NUM_LANES]
);

    dispatch_pkg::rob_state_e state [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::arch_addr_t dest  [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::data_t      value [dispatch_pkg::ROB_DEPTH];

    dispatch_pkg::rob_idx_t head;  // Oldest entry
    dispatch_pkg::rob_idx_t tail;  // Next to allocate
    logic [$clog2(dispatch_pkg::ROB_DEPTH+1)-1:0] count, n_alloc, n_commit;

    // Room for a full group keeps issue_ready lane independent
    assign has_room = count <= (dispatch_pkg::ROB_DEPTH - dispatch_pkg::NUM_LANES);

    // =====================================================================
    // Allocation and retirement selection
    // =====================================================================
    always_comb begin
        dispatch_pkg::rob_idx_t slot;
        logic run;
        slot     = tail;
        run      = 1'b1;
        n_alloc  = '0;
        n_commit = '0;
        for (int k = 0; k < dispatch_pkg::NUM_LANES; k++) begin
            alloc_idx[k] = slot;           // Consecutive in lane order
            if (alloc_en[k]) begin
                slot    = slot + 1'b1;
                n_alloc = n_alloc + 1'b1;
            end
            commit_idx[k]   = head + dispatch_pkg::rob_idx_t'(k);
            run             = run && (state[commit_idx[k]] == dispatch_pkg::ROB_DONE);
            commit_valid[k] = run;         // Leading run of done entries only
            commit_addr[k]  = dest[commit_idx[k]];
            commit_data[k]  = value[commit_idx[k]];
            if (run) n_commit = n_commit + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 2*dispatch_pkg::NUM_LANES; i++) begin
            rd_data[i] = value[rd_idx[i]];
            rd_done[i] = state[rd_idx[i]] == dispatch_pkg::ROB_DONE;
        end
    end

    // =====================================================================
    // Entry state and pointers
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < dispatch_pkg::ROB_DEPTH; i++) begin
                state[i] <= dispatch_pkg::ROB_FREE;
            end
        end else begin
            for (int k = 0; k < dispatch_pkg::NUM_LANES; k++) begin
                if (commit_valid[k]) state[commit_idx[k]] <= dispatch_pkg::ROB_FREE;
                if (cdb_valid[k] && cdb_dest[k][5] &&
                    state[cdb_dest[k][4:0]] == dispatch_pkg::ROB_BUSY) begin
                    state[cdb_dest[k][4:0]] <= dispatch_pkg::ROB_DONE;
                end
                if (alloc_en[k]) state[alloc_idx[k]] <= dispatch_pkg::ROB_BUSY;
            end
            head  <= head + dispatch_pkg::rob_idx_t'(n_commit);
            tail  <= tail + dispatch_pkg::rob_idx_t'(n_alloc);
            count <= count + n_alloc - n_commit;
        end
    end

    // Payload, only meaningful while the entry is busy or done
    always_ff @(posedge clk) begin
        for (int k = 0; k < dispatch_pkg::NUM_LANES; k++) begin
            if (alloc_en[k]) dest[alloc_idx[k]] <= alloc_arch[k];
            if (cdb_valid[k] && cdb_dest[k][5] &&
                state[cdb_dest[k][4:0]] == dispatch_pkg::ROB_BUSY) begin
                value[cdb_dest[k][4:0]] <= cdb_data[k];
            end
        end
    end

    for (genvar k = 0; k < dispatch_pkg::NUM_LANES; k++) begin : g_chk
        // Execution units only report entries still outstanding
        a_cdb_busy : assert property (@(posedge clk) disable iff (reset)
            cdb_valid[k] && cdb_dest[k][5] |->
                state[cdb_dest[k][4:0]] == dispatch_pkg::ROB_BUSY);
        if (k > 0) begin : g_contig
            a_commit_contig : assert property (@(posedge clk) disable iff (reset)
                commit_valid[k] |-> commit_valid[k-1] && count > k);
        end
    end

endmodule

//--- logic/arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  dispatch_pkg::arch_addr_t rd_addr     [2*dispatch_pkg::NUM_LANES],
    output dispatch_pkg::data_t      rd_data     [2*dispatch_pkg::NUM_LANES],
    input  logic [dispatch_pkg::NUM_LANES-1:0] commit_valid,
    input  dispatch_pkg::arch_addr_t commit_addr [dispatch_pkg::NUM_LANES],
    input  dispatch_pkg::data_t      commit_data [dispatch_pkg::NUM_LANES]
);

    dispatch_pkg::data_t regs [dispatch_pkg::ARCH_REGS];

    // =====================================================================
    // Commit write ports
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dispatch_pkg::ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Loop order gives the higher lane priority on the same register
            for (int k = 0; k < dispatch_pkg::NUM_LANES; k++) begin
                if (commit_valid[k] && commit_addr[k] != '0) begin
                    regs[commit_addr[k]] <= commit_data[k];
                end
            end
        end
    end

    // Combinational reads, x0 hardwired
    always_comb begin
        for (int i = 0; i < 2*dispatch_pkg::NUM_LANES; i++) begin
            rd_data[i] = (rd_addr[i] == '0) ? '0 : regs[rd_addr[i]];
        end
    end

    // ROB never allocates for x0, so nothing may retire into it
    for (genvar k = 0; k < dispatch_pkg::NUM_LANES; k++) begin : g_x0_chk
        a_no_x0_commit : assert property (@(posedge clk) disable iff (reset)
            commit_valid[k] |-> commit_addr[k] != '0);
    end

endmodule

//--- logic/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
    input  dispatch_pkg::phys_addr_t src_a,
    input  dispatch_pkg::phys_addr_t src_b,
    input  logic                     use_imm,
    input  dispatch_pkg::data_t      imm,
    input  dispatch_pkg::opcode_t    opcode,
    input  dispatch_pkg::rob_idx_t   rd_rob_idx,
    input  dispatch_pkg::data_t      rf_a,
    input  dispatch_pkg::data_t      rf_b,
    input  dispatch_pkg::data_t      rob_a,
    input  dispatch_pkg::data_t      rob_b,
    input  logic                     rob_a_done,
    input  logic                     rob_b_done,
    dispatch_lane_if.fetch           lane
);

    logic a_from_rob;
    logic b_from_rob;

    assign a_from_rob = src_a[$high(src_a)];  // MSB picks ROB over ARF
    assign b_from_rob = src_b[$high(src_b)];

    // Operand A, ARF value is always committed so always ready
    assign lane.a_data  = a_from_rob ? rob_a : rf_a;
    assign lane.a_ready = !a_from_rob || rob_a_done;
    assign lane.a_tag   = src_a[$high(src_a)-1:0];

    // Operand B, immediate overrides any register source
    assign lane.b_data  = use_imm ? imm : (b_from_rob ? rob_b : rf_b);
    assign lane.b_ready = use_imm || !b_from_rob || rob_b_done;
    assign lane.b_tag   = src_b[$high(src_b)-1:0];

    assign lane.opcode     = opcode;      // Passed through untouched
    assign lane.rd_rob_idx = rd_rob_idx;

endmodule

//--- logic/dispatch_lane_if.sv
`timescale 1ns/1ps

// One lane of resolved operands, fetch side to station side
interface dispatch_lane_if;

    dispatch_pkg::opcode_t  opcode;
    dispatch_pkg::data_t    a_data;
    logic                   a_ready;
    dispatch_pkg::rob_idx_t a_tag;      // Awaited entry when a_ready low
    dispatch_pkg::data_t    b_data;
    logic                   b_ready;
    dispatch_pkg::rob_idx_t b_tag;      // Awaited entry when b_ready low
    dispatch_pkg::rob_idx_t rd_rob_idx; // Entry this instruction completes

    modport fetch (
        output opcode, a_data, a_ready, a_tag, b_data, b_ready, b_tag, rd_rob_idx
    );

    modport station (
        input opcode, a_data, a_ready, a_tag, b_data, b_ready, b_tag, rd_rob_idx
    );

endinterface

//--- logic/dispatch_pkg.sv
package dispatch_pkg;

    // =====================================================================
    // Sizes
    // =====================================================================
    localparam int NUM_LANES  = 3;   // Issue, result bus and commit width
    localparam int DATA_WIDTH = 32;
    localparam int ARCH_REGS  = 32;
    localparam int ROB_DEPTH  = 32;

    // =====================================================================
    // Vector types
    // =====================================================================
    typedef logic [DATA_WIDTH-1:0]        data_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_addr_t;  // x0 reads zero
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;    // Also the wait tag
    typedef logic [$clog2(ROB_DEPTH):0]   phys_addr_t;  // MSB set selects ROB
    typedef logic [3:0]                   opcode_t;     // Opaque to this stage

    // =====================================================================
    // State machines
    // =====================================================================
    typedef enum logic [1:0] {
        ROB_FREE,
        ROB_BUSY,   // Allocated, result outstanding
        ROB_DONE    // Result captured, waiting to retire
    } rob_state_e;

    typedef enum logic [1:0] {
        RS_EMPTY,
        RS_WAITING, // At least one operand pending
        RS_READY    // Presented to execution unit
    } rs_state_e;

endpackage
